// File: source/i2s_rx_config.svh
// Sample width, FIFO sizing, bus widths and register map of the I2S receiver
`ifndef I2S_RX_CONFIG_SVH
`define I2S_RX_CONFIG_SVH

// ------------------------------
// Data path sizes
// ------------------------------
`define I2S_SAMPLE_W       16           // One audio word per channel
`define I2S_FIFO_DEPTH     16
`define I2S_LEVEL_W        5            // Must hold 0 to FIFO depth
`define I2S_ADDR_W         5
`define I2S_DATA_W         32
`define I2S_DEF_REG_VALUE  32'hDADDEFAC // Marks an undefined address

// ------------------------------
// Register map
// ------------------------------
`define I2S_REG_CTRL       5'h00
`define I2S_REG_INT_STS    5'h02
`define I2S_REG_INT_EN     5'h03
`define I2S_REG_DMA_START  5'h08
`define I2S_REG_DMA_STS    5'h09
`define I2S_REG_DMA_CNT    5'h0A
`define I2S_REG_RX_DATA    5'h10

`endif

// File: source/i2s_rx_pkg.sv
// Shared types of the I2S receiver: sample and bus structs, DMA states, register addresses
`default_nettype none
`include "i2s_rx_config.svh"

package i2s_rx_pkg;

	// ------------------------------
	// Payload and bus structs
	// ------------------------------

	// Channel tag sits in bit 16 of the receive data register
	typedef struct packed {
		logic                     right; // 0 left, 1 right
		logic [`I2S_SAMPLE_W-1:0] data;
	} i2s_sample_t;

	// Held by the master until acknowledge
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`I2S_ADDR_W-1:0] adr;
		logic [`I2S_DATA_W-1:0] dat;
	} wbs_req_t;

	// ------------------------------
	// Enums
	// ------------------------------
	typedef enum logic [1:0] {
		DMA_IDLE      = 2'd0,
		DMA_WAIT_DATA = 2'd1,
		DMA_REQUEST   = 2'd2,
		DMA_ACTIVE    = 2'd3
	} dma_state_e;

	typedef enum logic [`I2S_ADDR_W-1:0] {
		REG_CTRL      = `I2S_REG_CTRL,
		REG_INT_STS   = `I2S_REG_INT_STS,
		REG_INT_EN    = `I2S_REG_INT_EN,
		REG_DMA_START = `I2S_REG_DMA_START,
		REG_DMA_STS   = `I2S_REG_DMA_STS,
		REG_DMA_CNT   = `I2S_REG_DMA_CNT,
		REG_RX_DATA   = `I2S_REG_RX_DATA
	} reg_addr_e;

endpackage

`default_nettype wire

// File: source/i2s_deserializer.sv
// I2S line synchronizer, serial to parallel shifter and tagged sample emission
`timescale 1ns/10ps
`default_nettype none
`include "i2s_rx_config.svh"

module i2s_deserializer (
	input  logic                     wbs_clk_i,
	input  logic                     arst_n_i,
	input  logic                     i2s_clk_i,
	input  logic                     i2s_ws_i,
	input  logic                     i2s_din_i,
	input  logic                     rx_en_i,
	output i2s_rx_pkg::i2s_sample_t  sample_o,
	output logic                     push_o
);

	logic [1:0]               clk_sync;   // Two stages per line
	logic [1:0]               ws_sync;
	logic [1:0]               din_sync;
	logic                     clk_d;      // Previous synchronized I2S clock
	logic                     ws_prev;
	logic                     i2s_rise;
	logic                     ws_change;
	logic [`I2S_SAMPLE_W-1:0] shifter;
	logic [`I2S_SAMPLE_W-1:0] shift_next;

	// ------------------------------
	// Synchronizers and edge detect
	// ------------------------------
	always_ff @(posedge wbs_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			clk_sync <= '0;
			ws_sync  <= '0;
			din_sync <= '0;
			clk_d    <= 1'b0;
		end else begin
			clk_sync <= {clk_sync[0], i2s_clk_i};
			ws_sync  <= {ws_sync[0], i2s_ws_i};
			din_sync <= {din_sync[0], i2s_din_i};
			clk_d    <= clk_sync[1];
		end
	end

	assign i2s_rise   = clk_sync[1] & ~clk_d;
	assign ws_change  = ws_sync[1] ^ ws_prev;     // WS moves with the LSB
	assign shift_next = {shifter[`I2S_SAMPLE_W-2:0], din_sync[1]};

	// ------------------------------
	// Shift and emit
	// ------------------------------
	always_ff @(posedge wbs_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ws_prev <= 1'b0;
			push_o  <= 1'b0;
		end else begin
			push_o <= 1'b0;
			if (i2s_rise) begin
				ws_prev <= ws_sync[1];
				push_o  <= ws_change & rx_en_i;
			end
		end
	end

	// MSB first
	always_ff @(posedge wbs_clk_i) begin
		if (i2s_rise) begin
			shifter <= shift_next;
		end
	end

	// Word including the LSB just sampled, tagged with the old WS
	always_ff @(posedge wbs_clk_i) begin
		if (i2s_rise && ws_change) begin
			sample_o.right <= ws_prev;
			sample_o.data  <= shift_next;
		end
	end

endmodule

`default_nettype wire

// File: source/rx_sample_fifo.sv
// Circular receive sample buffer with level counter, flush and overflow pulse
`timescale 1ns/10ps
`default_nettype none
`include "i2s_rx_config.svh"

module rx_sample_fifo (
	input  logic                     wbs_clk_i,
	input  logic                     arst_n_i,
	input  logic                     push_i,
	input  logic                     pop_i,
	input  logic                     flush_i,
	input  i2s_rx_pkg::i2s_sample_t  sample_i,
	output i2s_rx_pkg::i2s_sample_t  head_o,
	output logic [`I2S_LEVEL_W-1:0]  level_o,
	output logic                     empty_o,
	output logic                     pop_done_o,
	output logic                     overflow_o
);

	localparam int AW = $clog2(`I2S_FIFO_DEPTH);

	i2s_rx_pkg::i2s_sample_t mem [`I2S_FIFO_DEPTH];
	logic [AW-1:0]           wr_ptr;
	logic [AW-1:0]           rd_ptr;
	logic                    full;
	logic                    push_ok;
	logic                    pop_ok;

	assign full    = (level_o == `I2S_LEVEL_W'(`I2S_FIFO_DEPTH));
	assign empty_o = (level_o == '0);
	assign push_ok = push_i & ~full;
	assign pop_ok  = pop_i & ~empty_o;  // Pop on empty is ignored
	assign head_o  = mem[rd_ptr];

	// ------------------------------
	// Pointers and level
	// ------------------------------
	always_ff @(posedge wbs_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			level_o    <= '0;
			pop_done_o <= 1'b0;
			overflow_o <= 1'b0;
		end else begin
			pop_done_o <= pop_ok & ~flush_i;
			overflow_o <= push_i & full;    // Sample is lost
			if (flush_i) begin
				wr_ptr  <= '0;
				rd_ptr  <= '0;
				level_o <= '0;
			end else begin
				if (push_ok) begin
					wr_ptr <= wr_ptr + 1'b1;   // Wraps, depth is a power of two
				end
				if (pop_ok) begin
					rd_ptr <= rd_ptr + 1'b1;
				end
				case ({push_ok, pop_ok})
					2'b10:   level_o <= level_o + 1'b1;
					2'b01:   level_o <= level_o - 1'b1;
					default: level_o <= level_o;
				endcase
			end
		end
	end

	// Storage
	always_ff @(posedge wbs_clk_i) begin
		if (push_ok) begin
			mem[wr_ptr] <= sample_i;
		end
	end

endmodule

`default_nettype wire

// File: source/dma_request_fsm.sv
// DMA burst sequencer from start through request and pop counting to done
`timescale 1ns/10ps
`default_nettype none
`include "i2s_rx_config.svh"

module dma_request_fsm (
	input  logic                    wbs_clk_i,
	input  logic                    arst_n_i,
	input  logic                    start_i,
	input  logic                    dma_active_i,
	input  logic                    pop_done_i,
	input  logic [`I2S_LEVEL_W-1:0] dma_cnt_i,
	input  logic [`I2S_LEVEL_W-1:0] level_i,
	output logic                    dma_req_o,
	output logic                    busy_o,
	output logic                    done_o
);

	i2s_rx_pkg::dma_state_e  state;
	logic [`I2S_LEVEL_W-1:0] word_cnt;  // Words popped in this burst
	logic                    last_word;

	assign busy_o    = (state != i2s_rx_pkg::DMA_IDLE);
	assign last_word = (word_cnt == dma_cnt_i - 1'b1);

	// ------------------------------
	// Burst state machine
	// ------------------------------
	always_ff @(posedge wbs_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state     <= i2s_rx_pkg::DMA_IDLE;
			word_cnt  <= '0;
			dma_req_o <= 1'b0;
			done_o    <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				i2s_rx_pkg::DMA_IDLE: begin
					word_cnt <= '0;
					if (start_i) begin
						state <= i2s_rx_pkg::DMA_WAIT_DATA;
					end
				end
				i2s_rx_pkg::DMA_WAIT_DATA: begin
					// Whole burst buffered
					if (level_i >= dma_cnt_i) begin
						state     <= i2s_rx_pkg::DMA_REQUEST;
						dma_req_o <= 1'b1;
					end
				end
				i2s_rx_pkg::DMA_REQUEST: begin
					if (dma_active_i) begin
						state     <= i2s_rx_pkg::DMA_ACTIVE;
						dma_req_o <= 1'b0;
					end
				end
				i2s_rx_pkg::DMA_ACTIVE: begin
					if (pop_done_i) begin
						if (last_word) begin
							state  <= i2s_rx_pkg::DMA_IDLE;
							done_o <= 1'b1;   // One cycle
						end else begin
							word_cnt <= word_cnt + 1'b1;
						end
					end
				end
				default: state <= i2s_rx_pkg::DMA_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/i2s_rx_registers.sv
// Register decode, bus acknowledge, control, status and masked interrupt outputs
`timescale 1ns/10ps
`default_nettype none
`include "i2s_rx_config.svh"

module i2s_rx_registers (
	input  logic                     wbs_clk_i,
	input  logic                     arst_n_i,
	input  i2s_rx_pkg::wbs_req_t     wbs_req_i,
	output logic [`I2S_DATA_W-1:0]   wbs_dat_o,
	output logic                     wbs_ack_o,
	input  i2s_rx_pkg::i2s_sample_t  head_i,
	input  logic                     empty_i,
	input  logic [`I2S_LEVEL_W-1:0]  level_i,
	input  logic                     busy_i,
	input  logic                     dma_done_i,
	input  logic                     overflow_i,
	output logic                     rx_en_o,
	output logic                     flush_o,
	output logic                     pop_o,
	output logic                     dma_start_o,
	output logic [`I2S_LEVEL_W-1:0]  dma_cnt_o,
	output logic                     dma_intr_o,
	output logic                     ovf_intr_o
);

	logic                   req_hit;   // New access, not yet acknowledged
	logic                   wr_hit;
	logic                   rd_hit;
	logic [1:0]             int_sts;   // Bit 0 DMA done, bit 1 overflow
	logic [1:0]             int_en;
	logic [1:0]             sts_set;
	logic [`I2S_DATA_W-1:0] rd_data;

	assign req_hit = wbs_req_i.cyc & wbs_req_i.stb & ~wbs_ack_o;
	assign wr_hit  = req_hit & wbs_req_i.we;
	assign rd_hit  = req_hit & ~wbs_req_i.we;
	assign sts_set = {overflow_i, dma_done_i};

	// ------------------------------
	// Strobes to the data path
	// ------------------------------
	// Enable going 1 to 0 drops whatever is buffered
	assign flush_o = wr_hit & (wbs_req_i.adr == i2s_rx_pkg::REG_CTRL)
		& rx_en_o & ~wbs_req_i.dat[0];
	assign pop_o       = rd_hit & (wbs_req_i.adr == i2s_rx_pkg::REG_RX_DATA);
	assign dma_start_o = wr_hit & (wbs_req_i.adr == i2s_rx_pkg::REG_DMA_START)
		& wbs_req_i.dat[0];

	// ------------------------------
	// Acknowledge and writes
	// ------------------------------
	always_ff @(posedge wbs_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wbs_ack_o <= 1'b0;
			rx_en_o   <= 1'b0;
			int_sts   <= '0;
			int_en    <= '0;
			dma_cnt_o <= '0;
		end else begin
			wbs_ack_o <= req_hit;  // Single cycle
			if (wr_hit) begin
				case (wbs_req_i.adr)
					i2s_rx_pkg::REG_CTRL:    rx_en_o   <= wbs_req_i.dat[0];
					i2s_rx_pkg::REG_INT_EN:  int_en    <= wbs_req_i.dat[1:0];
					i2s_rx_pkg::REG_DMA_CNT: dma_cnt_o <= wbs_req_i.dat[`I2S_LEVEL_W-1:0];
					default: ;
				endcase
			end
			// New events win over a clear in the same cycle
			if (wr_hit && wbs_req_i.adr == i2s_rx_pkg::REG_INT_STS) begin
				int_sts <= (int_sts & ~wbs_req_i.dat[1:0]) | sts_set;
			end else begin
				int_sts <= int_sts | sts_set;
			end
		end
	end

	// ------------------------------
	// Read mux
	// ------------------------------
	always_comb begin
		rd_data = '0;
		case (wbs_req_i.adr)
			i2s_rx_pkg::REG_CTRL:      rd_data[0] = rx_en_o;
			i2s_rx_pkg::REG_INT_STS:   rd_data[1:0] = int_sts;
			i2s_rx_pkg::REG_INT_EN:    rd_data[1:0] = int_en;
			i2s_rx_pkg::REG_DMA_START: rd_data = '0;   // Write only
			i2s_rx_pkg::REG_DMA_STS: begin
				rd_data[0]    = busy_i;
				rd_data[12:8] = level_i;
			end
			i2s_rx_pkg::REG_DMA_CNT:   rd_data[`I2S_LEVEL_W-1:0] = dma_cnt_o;
			i2s_rx_pkg::REG_RX_DATA: begin
				if (!empty_i) begin
					rd_data[$bits(head_i)-1:0] = head_i;
				end
			end
			default:                   rd_data = `I2S_DEF_REG_VALUE;
		endcase
	end

	// Captured with the old FIFO head, valid in the ack cycle
	always_ff @(posedge wbs_clk_i) begin
		if (rd_hit) begin
			wbs_dat_o <= rd_data;
		end
	end

	// Masked interrupts
	always_ff @(posedge wbs_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dma_intr_o <= 1'b0;
			ovf_intr_o <= 1'b0;
		end else begin
			dma_intr_o <= int_sts[0] & int_en[0];
			ovf_intr_o <= int_sts[1] & int_en[1];
		end
	end

endmodule

`default_nettype wire

// File: source/i2s_rx_dma_top.sv
// Top level of the I2S receiver with DMA, connecting deserializer, FIFO, FSM and registers
`timescale 1ns/10ps
`default_nettype none
`include "i2s_rx_config.svh"

module i2s_rx_dma_top (
	input  logic                    wbs_clk_i,
	input  logic                    arst_n_i,
	input  logic                    i2s_clk_i,
	input  logic                    i2s_ws_i,
	input  logic                    i2s_din_i,
	input  logic                    dma_active_i,
	input  i2s_rx_pkg::wbs_req_t    wbs_req_i,
	output logic [`I2S_DATA_W-1:0]  wbs_dat_o,
	output logic                    wbs_ack_o,
	output logic                    dma_req_o,
	output logic                    dma_intr_o,
	output logic                    ovf_intr_o
);

	// ------------------------------
	// Internal nets
	// ------------------------------
	i2s_rx_pkg::i2s_sample_t rx_sample;
	i2s_rx_pkg::i2s_sample_t fifo_head;
	logic                    rx_push;
	logic                    rx_en;
	logic                    fifo_flush;
	logic                    fifo_pop;
	logic                    fifo_empty;
	logic                    pop_done;
	logic                    overflow;
	logic [`I2S_LEVEL_W-1:0] fifo_level;
	logic [`I2S_LEVEL_W-1:0] dma_cnt;
	logic                    dma_start;
	logic                    dma_busy;
	logic                    dma_done;

	i2s_deserializer u_i2s_deserializer (
		.wbs_clk_i (wbs_clk_i),
		.arst_n_i  (arst_n_i),
		.i2s_clk_i (i2s_clk_i),
		.i2s_ws_i  (i2s_ws_i),
		.i2s_din_i (i2s_din_i),
		.rx_en_i   (rx_en),
		.sample_o  (rx_sample),
		.push_o    (rx_push)
	);

	rx_sample_fifo u_rx_sample_fifo (
		.wbs_clk_i  (wbs_clk_i),
		.arst_n_i   (arst_n_i),
		.push_i     (rx_push),
		.pop_i      (fifo_pop),
		.flush_i    (fifo_flush),
		.sample_i   (rx_sample),
		.head_o     (fifo_head),
		.level_o    (fifo_level),
		.empty_o    (fifo_empty),
		.pop_done_o (pop_done),
		.overflow_o (overflow)
	);

	dma_request_fsm u_dma_request_fsm (
		.wbs_clk_i    (wbs_clk_i),
		.arst_n_i     (arst_n_i),
		.start_i      (dma_start),
		.dma_active_i (dma_active_i),
		.pop_done_i   (pop_done),
		.dma_cnt_i    (dma_cnt),
		.level_i      (fifo_level),
		.dma_req_o    (dma_req_o),
		.busy_o       (dma_busy),
		.done_o       (dma_done)
	);

	i2s_rx_registers u_i2s_rx_registers (
		.wbs_clk_i   (wbs_clk_i),
		.arst_n_i    (arst_n_i),
		.wbs_req_i   (wbs_req_i),
		.wbs_dat_o   (wbs_dat_o),
		.wbs_ack_o   (wbs_ack_o),
		.head_i      (fifo_head),
		.empty_i     (fifo_empty),
		.level_i     (fifo_level),
		.busy_i      (dma_busy),
		.dma_done_i  (dma_done),
		.overflow_i  (overflow),
		.rx_en_o     (rx_en),
		.flush_o     (fifo_flush),
		.pop_o       (fifo_pop),
		.dma_start_o (dma_start),
		.dma_cnt_o   (dma_cnt),
		.dma_intr_o  (dma_intr_o),
		.ovf_intr_o  (ovf_intr_o)
	);

endmodule

`default_nettype wire

// File: verification/tb_i2s_rx_dma.sv
// Testbench of the I2S receiver top with bus and I2S drivers, case file reader and checks
`timescale 1ns/10ps
`default_nettype none
`include "i2s_rx_config.svh"

module tb_i2s_rx_dma;

	localparam int OP_WRITE    = 0;
	localparam int OP_READ     = 1;
	localparam int OP_FRAME    = 2;
	localparam int OP_DMARUN   = 3;
	localparam int OP_CHECKPIN = 4;

	logic                   wbs_clk;
	logic                   arst_n;
	logic                   i2s_clk;
	logic                   i2s_ws;
	logic                   i2s_din;
	logic                   dma_active;
	i2s_rx_pkg::wbs_req_t   wbs_req;
	logic [`I2S_DATA_W-1:0] wbs_dat;
	logic                   wbs_ack;
	logic                   dma_req;
	logic                   dma_intr;
	logic                   ovf_intr;

	int                     op_code[$];    // Parsed case file
	logic [31:0]            arg_a[$];
	logic [31:0]            arg_b[$];
	logic [16:0]            model_q[$];    // Expected FIFO contents
	logic                   rx_en_model;
	int                     cycle_cnt;
	int                     cycle_limit;

	i2s_rx_dma_top dut_i (
		.wbs_clk_i    (wbs_clk),
		.arst_n_i     (arst_n),
		.i2s_clk_i    (i2s_clk),
		.i2s_ws_i     (i2s_ws),
		.i2s_din_i    (i2s_din),
		.dma_active_i (dma_active),
		.wbs_req_i    (wbs_req),
		.wbs_dat_o    (wbs_dat),
		.wbs_ack_o    (wbs_ack),
		.dma_req_o    (dma_req),
		.dma_intr_o   (dma_intr),
		.ovf_intr_o   (ovf_intr)
	);

	initial begin
		wbs_clk = 1'b0;
		forever #10 wbs_clk = ~wbs_clk;
	end

	// ------------------------------
	// Failure handling
	// ------------------------------
	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// Watchdog
	always @(posedge wbs_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			$display("ERROR: the run did not finish within %0d clock cycles", cycle_limit);
			stop_with_failure();
		end
	end

	// ------------------------------
	// Bus and pin helpers
	// ------------------------------
	task automatic bus_access(input logic we, input logic [4:0] adr,
		input logic [31:0] wdat, output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(posedge wbs_clk);
		#2;
		wbs_req.cyc = 1'b1;
		wbs_req.stb = 1'b1;
		wbs_req.we  = we;
		wbs_req.adr = adr;
		wbs_req.dat = wdat;
		do begin
			@(posedge wbs_clk);
			waited++;
			@(negedge wbs_clk);
		end while (wbs_ack !== 1'b1 && waited < 8);
		if (wbs_ack !== 1'b1) begin
			$display("ERROR: no bus acknowledge for address 0x%02h", adr);
			stop_with_failure();
		end
		check_value("wbs_ack_o delay", waited, 1);
		rdat = wbs_dat;
		@(posedge wbs_clk);
		#2 wbs_req = '0;
		@(negedge wbs_clk);
		check_value("wbs_ack_o", wbs_ack, 0);   // Only one ack cycle
	endtask

	function automatic logic pin_value(input int sel);
		case (sel)
			0:       return dma_req;
			1:       return dma_intr;
			default: return ovf_intr;
		endcase
	endfunction

	function automatic string pin_name(input int sel);
		case (sel)
			0:       return "dma_req_o";
			1:       return "dma_intr_o";
			default: return "ovf_intr_o";
		endcase
	endfunction

	// Registered outputs settle within a few cycles
	task automatic expect_pin(input int sel, input logic level);
		int   waited;
		logic val;
		waited = 0;
		@(negedge wbs_clk);
		val = pin_value(sel);
		while (val !== level && waited < 8) begin
			@(negedge wbs_clk);
			val = pin_value(sel);
			waited++;
		end
		check_value(pin_name(sel), val, level);
	endtask

	// ------------------------------
	// I2S frame driver
	// ------------------------------
	// 8 bus cycles per bit, WS flips with each LSB
	task automatic send_frame(input logic [15:0] left, input logic [15:0] right);
		logic [31:0] word;
		int          i;
		word = {left, right};
		for (i = 0; i < 32; i++) begin
			@(posedge wbs_clk);
			#2;
			i2s_clk = 1'b0;
			i2s_din = word[31-i];
			i2s_ws  = (i >= 15 && i < 31);
			repeat (4) @(posedge wbs_clk);
			#2 i2s_clk = 1'b1;
			repeat (3) @(posedge wbs_clk);
		end
		@(posedge wbs_clk);
		#2 i2s_clk = 1'b0;     // Trailing edge
		repeat (4) @(posedge wbs_clk);
	endtask

	// ------------------------------
	// DMA burst
	// ------------------------------
	task automatic run_dma_burst(input int words);
		int          waited;
		int          i;
		logic [31:0] rd;
		logic [31:0] exp;
		waited = 0;
		while (dma_req !== 1'b1 && waited < 64) begin
			@(negedge wbs_clk);
			waited++;
		end
		if (dma_req !== 1'b1) begin
			$display("ERROR: the DMA request never rose");
			stop_with_failure();
		end
		@(posedge wbs_clk);
		#2 dma_active = 1'b1;
		waited = 0;
		do begin
			@(negedge wbs_clk);
			waited++;
		end while (dma_req === 1'b1 && waited < 8);
		check_value("dma_req_o", dma_req, 0);
		@(posedge wbs_clk);
		#2 dma_active = 1'b0;
		for (i = 0; i < words; i++) begin
			exp = '0;
			if (model_q.size() > 0) begin
				exp = model_q.pop_front();
			end
			bus_access(1'b0, `I2S_REG_RX_DATA, '0, rd);
			check_value("wbs_dat_o DMA word", rd, exp);
		end
	endtask

	// ------------------------------
	// Case file reader
	// ------------------------------
	task automatic load_cases();
		int              fd;
		int              n;
		logic [8*128-1:0] line;
		logic [8*8-1:0]  op;
		logic [31:0]     f1;
		logic [31:0]     f2;
		fd = $fopen("verification/i2s_rx_cases.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open the case file");
			stop_with_failure();
		end
		while (!$feof(fd)) begin
			line = '0;
			op   = '0;
			if ($fgets(line, fd) > 0) begin
				n = $sscanf(line, "%s %h %h", op, f1, f2);
				if (n == 3 && op != "#") begin
					case (op)
						"write":    op_code.push_back(OP_WRITE);
						"read":     op_code.push_back(OP_READ);
						"frame":    op_code.push_back(OP_FRAME);
						"dmarun":   op_code.push_back(OP_DMARUN);
						"checkpin": op_code.push_back(OP_CHECKPIN);
						default: begin
							$display("ERROR: unknown command in the case file");
							stop_with_failure();
						end
					endcase
					arg_a.push_back(f1);
					arg_b.push_back(f2);
				end else if (n >= 1 && op != "#") begin
					$display("ERROR: a case line has too few fields");
					stop_with_failure();
				end
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		int          i;
		int          frames;
		int          ops;
		logic [31:0] rd;
		wbs_req     = '0;
		i2s_clk     = 1'b0;
		i2s_ws      = 1'b0;
		i2s_din     = 1'b0;
		dma_active  = 1'b0;
		arst_n      = 1'b0;
		rx_en_model = 1'b0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		frames      = 0;
		ops         = 0;
		load_cases();
		for (i = 0; i < op_code.size(); i++) begin
			if (op_code[i] == OP_FRAME) frames++;
			else if (op_code[i] == OP_DMARUN) ops += arg_a[i] + 2;
			else ops++;
		end
		cycle_limit = 2 * (260 * frames + 4 * ops);
		repeat (8) @(posedge wbs_clk);
		#2 arst_n = 1'b1;
		for (i = 0; i < op_code.size(); i++) begin
			case (op_code[i])
				OP_WRITE: begin
					bus_access(1'b1, arg_a[i][4:0], arg_b[i], rd);
					if (arg_a[i][4:0] == `I2S_REG_CTRL) begin
						if (rx_en_model && !arg_b[i][0]) model_q.delete();  // Flush
						rx_en_model = arg_b[i][0];
					end
				end
				OP_READ: begin
					bus_access(1'b0, arg_a[i][4:0], '0, rd);
					check_value($sformatf("wbs_dat_o at 0x%02h", arg_a[i][4:0]), rd, arg_b[i]);
					if (arg_a[i][4:0] == `I2S_REG_RX_DATA && model_q.size() > 0) begin
						void'(model_q.pop_front());
					end
				end
				OP_FRAME: begin
					if (rx_en_model && model_q.size() < `I2S_FIFO_DEPTH) begin
						model_q.push_back({1'b0, arg_a[i][15:0]});
					end
					if (rx_en_model && model_q.size() < `I2S_FIFO_DEPTH) begin
						model_q.push_back({1'b1, arg_b[i][15:0]});
					end
					send_frame(arg_a[i][15:0], arg_b[i][15:0]);
				end
				OP_DMARUN:   run_dma_burst(arg_a[i]);
				default:     expect_pin(arg_a[i], arg_b[i][0]);
			endcase
		end
		repeat (2) @(posedge wbs_clk);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/i2s_rx_cases.txt
# op field1 field2, all hex: write addr data, read addr expected, frame left right
# dmarun words 0, checkpin pin level (pin 0 dma_req_o, 1 dma_intr_o, 2 ovf_intr_o)
read 00 00000000
read 03 00000000
write 03 00000003
read 03 00000003
write 0A 0000000C
read 0A 0000000C
read 01 DADDEFAC
read 1F DADDEFAC
write 03 00000000
write 00 00000001
frame 1234 ABCD
frame 5A5A 0F0F
read 09 00000400
read 10 00001234
read 10 0001ABCD
read 10 00005A5A
read 10 00010F0F
read 10 00000000
write 00 00000000
frame 1111 2222
read 09 00000000
write 00 00000001
frame 3333 4444
read 09 00000200
write 00 00000000
read 09 00000000
write 00 00000001
frame 0001 8001
frame 0002 8002
frame 0003 8003
frame 0004 8004
frame 0005 8005
frame 0006 8006
frame 0007 8007
frame 0008 8008
frame 0009 8009
read 09 00001000
read 02 00000002
checkpin 2 0
write 03 00000002
checkpin 2 1
write 02 00000002
read 02 00000000
checkpin 2 0
write 00 00000000
write 00 00000001
write 03 00000003
write 0A 00000004
write 08 00000001
read 09 00000001
frame 0101 0202
frame 0303 0404
checkpin 0 1
dmarun 4 0
checkpin 1 1
read 02 00000001
read 09 00000000
write 02 00000001
read 02 00000000
checkpin 1 0

// File: compile.f
+incdir+source
source/i2s_rx_pkg.sv
source/i2s_deserializer.sv
source/rx_sample_fifo.sv
source/dma_request_fsm.sv
source/i2s_rx_registers.sv
source/i2s_rx_dma_top.sv
verification/tb_i2s_rx_dma.sv
